//--- verilog/poly_mm_pkg.sv
package poly_mm_pkg;

    // coefficient width of the datapath
    localparam int coef_w = 24;

    // operands, modulus and result
    typedef logic [coef_w-1:0] coef_t;

    // barrett constant, quotient estimates and remainder
    // one bit wider than a coefficient
    typedef logic [coef_w:0] wide_t;

    // full operand product
    typedef logic [2*coef_w-1:0] prod_t;

    // quotient estimate times barrett constant
    typedef logic [2*coef_w+1:0] qmul_t;

    // modulus bit length, legal range 1 to 24
    typedef logic [4:0] nbits_t;

    // blinding lfsr state
    typedef logic [coef_w-1:0] lfsr_t;

    // restart value of the lfsr, must be nonzero
    localparam lfsr_t lfsr_default_seed = 24'h5A3C96;

    // feedback taps at bits 23, 21, 19 and 17
    localparam lfsr_t lfsr_taps = 24'hAA0000;

    // enable to valid latency in cycles
    localparam int pipe_depth = 4;

endpackage

//--- verilog/blind_lfsr.sv
`timescale 1ns/100ps

module blind_lfsr #(
    parameter poly_mm_pkg::lfsr_t lfsr_seed = poly_mm_pkg::lfsr_default_seed
) (
    input  logic poly_mm_clk,
    input  logic poly_mm_rst_n,
    input  logic enable,
    output logic blind_bit
);

    import poly_mm_pkg::*;

    lfsr_t lfsr_state;
    logic  feedback;

    // fibonacci feedback, xor of all tapped bits
    assign feedback = ^(lfsr_state & lfsr_taps);

    // one step per accepted item
    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            lfsr_state <= lfsr_seed;
        end else if (lfsr_state == '0) begin
            // stuck state, restart from the seed
            lfsr_state <= lfsr_seed;
        end else if (enable) begin
            lfsr_state <= {lfsr_state[$bits(lfsr_t)-2:0], feedback};
        end
    end

    // lsb decides blinding of the item presented now
    assign blind_bit = lfsr_state[0];

    // tap on the msb keeps the map invertible
    // so a nonzero seed never walks into zero
    assert property (
        @(posedge poly_mm_clk) disable iff (!poly_mm_rst_n)
        lfsr_state != '0
    ) else $error("blind lfsr reached the all zero state");

endmodule

//--- verilog/blind_unit.sv
`timescale 1ns/100ps

module blind_unit (
    input  logic               poly_mm_clk,
    input  logic               poly_mm_rst_n,
    input  logic               enable,
    input  logic               blind_bit,
    input  poly_mm_pkg::coef_t b,
    input  poly_mm_pkg::coef_t q,
    input  poly_mm_pkg::coef_t candidate,
    output poly_mm_pkg::coef_t b_blinded,
    output logic               valid,
    output poly_mm_pkg::coef_t result
);

    import poly_mm_pkg::*;

    // blind flag of the item entering at the current edge
    logic                  blind_tag;
    // older blind flags, msb lines up with the candidate
    logic [pipe_depth-2:0] blind_hist;
    // enable tags, msb marks a live candidate
    logic [pipe_depth-1:0] en_pipe;
    // candidate with the blinding removed
    coef_t                 unblinded;

    // negate b mod q when the lfsr asks for it
    // b below q gives a value in 1..q
    assign b_blinded = blind_bit ? (q - b) : b;

    // blind tag follows its item through the datapath
    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            blind_tag  <= 1'b0;
            blind_hist <= '0;
        end else begin
            blind_tag  <= blind_bit;
            blind_hist <= {blind_hist[pipe_depth-3:0], blind_tag};
        end
    end

    // enable chain, one stage per datapath register
    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            en_pipe <= '0;
        end else begin
            en_pipe <= {en_pipe[pipe_depth-2:0], enable};
        end
    end

    // a*(q-b) = -(a*b) mod q
    // zero stays zero, anything else goes back to q minus it
    assign unblinded = (blind_hist[pipe_depth-2] && (candidate != '0))
                     ? (q - candidate)
                     : candidate;

    // output stage
    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            valid  <= 1'b0;
            result <= '0;
        end else begin
            valid <= en_pipe[pipe_depth-1];
            // result only moves for a live item
            if (en_pipe[pipe_depth-1]) begin
                result <= unblinded;
            end
        end
    end

    // reduction plus unblinding must land in 0..q-1
    // q taken at the load edge of the result
    assert property (
        @(posedge poly_mm_clk) disable iff (!poly_mm_rst_n)
        valid |-> (result < $past(q))
    ) else $error("result not below the modulus while valid");

endmodule

//--- verilog/barrett_quotient.sv
`timescale 1ns/100ps

module barrett_quotient (
    input  logic                poly_mm_clk,
    input  logic                poly_mm_rst_n,
    input  poly_mm_pkg::coef_t  a,
    input  poly_mm_pkg::coef_t  b_blinded,
    input  poly_mm_pkg::wide_t  m,
    input  poly_mm_pkg::nbits_t n_bits,
    output poly_mm_pkg::prod_t  product,
    output poly_mm_pkg::wide_t  quot_est
);

    import poly_mm_pkg::*;

    // operand registers, loaded at the enable edge
    coef_t a_r;
    coef_t b_r;
    // first estimate, product >> (n_bits-1)
    wide_t est1_next;
    wide_t est1;
    // first estimate times barrett constant
    qmul_t est_prod;
    // second estimate before its register
    wide_t quot_next;

    // capture the item
    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            a_r <= '0;
            b_r <= '0;
        end else begin
            a_r <= a;
            b_r <= b_blinded;
        end
    end

    // full 48-bit product, also feeds the remainder side
    assign product = prod_t'(a_r) * prod_t'(b_r);

    // product below q^2 < 2^(2n)
    // so the shifted value fits n+1 bits
    assign est1_next = wide_t'(product >> (n_bits - 5'd1));

    // stage 1 estimate
    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            est1 <= '0;
        end else begin
            est1 <= est1_next;
        end
    end

    // m = floor(2^(2n)/q)
    // est1*m >> (n+1) approximates product/q from below
    assign est_prod  = qmul_t'(est1) * qmul_t'(m);
    assign quot_next = wide_t'(est_prod >> (n_bits + 5'd1));

    // stage 2 estimate
    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            quot_est <= '0;
        end else begin
            quot_est <= quot_next;
        end
    end

endmodule

//--- verilog/barrett_remainder.sv
`timescale 1ns/100ps

module barrett_remainder (
    input  logic                poly_mm_clk,
    input  logic                poly_mm_rst_n,
    input  poly_mm_pkg::prod_t  product,
    input  poly_mm_pkg::wide_t  quot_est,
    input  poly_mm_pkg::coef_t  q,
    input  poly_mm_pkg::nbits_t n_bits,
    output poly_mm_pkg::coef_t  candidate
);

    import poly_mm_pkg::*;

    // low n_bits+1 ones
    // n_bits = 24 wraps to all 25 bits set
    wide_t rem_mask;
    // low part of the product, masked
    wide_t prod_low;
    // product low part delayed to meet the q multiple
    wide_t low_d0;
    wide_t low_d1;
    wide_t low_d2;
    // quotient estimate times q
    qmul_t q_mult_full;
    wide_t q_mult_r;
    // remainder before the final correction
    wide_t rem_raw;
    wide_t rem_masked;
    wide_t rem_sub;
    // modulus widened to remainder width
    wide_t q_wide;

    assign q_wide   = {1'b0, q};
    assign rem_mask = (wide_t'(1) << (n_bits + 5'd1)) - wide_t'(1);

    // true remainder is below 2^(n+1)
    // so only the low n+1 bits of each side matter
    assign prod_low    = product[coef_w:0] & rem_mask;
    assign q_mult_full = qmul_t'(quot_est) * qmul_t'(q);

    // q multiple register
    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            q_mult_r <= '0;
        end else begin
            q_mult_r <= q_mult_full[coef_w:0] & rem_mask;
        end
    end

    // three stage delay of the low product
    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            low_d0 <= '0;
            low_d1 <= '0;
            low_d2 <= '0;
        end else begin
            low_d0 <= prod_low;
            low_d1 <= low_d0;
            low_d2 <= low_d1;
        end
    end

    // subtraction mod 2^(n+1)
    assign rem_raw    = low_d2 - q_mult_r;
    assign rem_masked = rem_raw & rem_mask;

    // one conditional subtraction of q
    assign rem_sub   = rem_masked - q_wide;
    assign candidate = (rem_masked < q_wide) ? rem_masked[coef_w-1:0]
                                             : rem_sub[coef_w-1:0];

    // estimate may be one short of the true quotient
    // holds for products below q^2 with config held over the item
    assert property (
        @(posedge poly_mm_clk) disable iff (!poly_mm_rst_n)
        (($past(product, 3) < (prod_t'(q) * prod_t'(q)))
            && (q == $past(q, 3))
            && (n_bits == $past(n_bits, 3)))
        |-> (rem_masked < (q_wide << 1))
    ) else $error("barrett remainder not below twice the modulus");

endmodule

//--- verilog/poly_mm_barrett.sv
`timescale 1ns/100ps

module poly_mm_barrett #(
    parameter poly_mm_pkg::lfsr_t lfsr_seed = poly_mm_pkg::lfsr_default_seed
) (
    input  logic                poly_mm_clk,
    input  logic                poly_mm_rst_n,
    input  logic                enable,
    input  poly_mm_pkg::coef_t  a,
    input  poly_mm_pkg::coef_t  b,
    input  poly_mm_pkg::coef_t  q,
    input  poly_mm_pkg::nbits_t n_bits,
    input  poly_mm_pkg::wide_t  m,
    output logic                valid,
    output poly_mm_pkg::coef_t  result
);

    import poly_mm_pkg::*;

    // per item blinding decision
    logic  blind_bit;
    // operand b after optional negation mod q
    coef_t b_blinded;
    // full product, valid one cycle after enable
    prod_t product;
    // second quotient estimate
    wide_t quot_est;
    // reduced value before unblinding
    coef_t candidate;

    // blinding decision source
    blind_lfsr #(
        .lfsr_seed     (lfsr_seed)
    ) u_blind_lfsr (
        .poly_mm_clk   (poly_mm_clk),
        .poly_mm_rst_n (poly_mm_rst_n),
        .enable        (enable),
        .blind_bit     (blind_bit)
    );

    // blinding in front, unblinding and output regs at the back
    blind_unit u_blind_unit (
        .poly_mm_clk   (poly_mm_clk),
        .poly_mm_rst_n (poly_mm_rst_n),
        .enable        (enable),
        .blind_bit     (blind_bit),
        .b             (b),
        .q             (q),
        .candidate     (candidate),
        .b_blinded     (b_blinded),
        .valid         (valid),
        .result        (result)
    );

    // product and quotient estimate stages
    barrett_quotient u_barrett_quotient (
        .poly_mm_clk   (poly_mm_clk),
        .poly_mm_rst_n (poly_mm_rst_n),
        .a             (a),
        .b_blinded     (b_blinded),
        .m             (m),
        .n_bits        (n_bits),
        .product       (product),
        .quot_est      (quot_est)
    );

    // q multiple, subtraction and final correction
    barrett_remainder u_barrett_remainder (
        .poly_mm_clk   (poly_mm_clk),
        .poly_mm_rst_n (poly_mm_rst_n),
        .product       (product),
        .quot_est      (quot_est),
        .q             (q),
        .n_bits        (n_bits),
        .candidate     (candidate)
    );

endmodule

//--- verification/tb_poly_mm_tasks.svh
`ifndef TB_POLY_MM_TASKS_SVH
`define TB_POLY_MM_TASKS_SVH

// reference model for a*b mod q in 64 bits
function automatic coef_t mod_mult(coef_t x, coef_t y, coef_t modulus);
    logic [63:0] p;
    p = (64'(x) * 64'(y)) % 64'(modulus);
    return p[23:0];
endfunction

// index of the highest set bit plus one
function automatic nbits_t bit_length(coef_t v);
    nbits_t len;
    int     i;
    len = '0;
    for (i = 0; i < 24; i++) begin
        if (v[i]) len = 5'(i + 1);
    end
    return len;
endfunction

// uniform-ish value in 0..bound-1
function automatic coef_t rand_below(coef_t bound);
    int          r;
    logic [31:0] u;
    r = $random(seed);
    u = r;
    return 24'(u % {8'd0, bound});
endfunction

// modulus, its bit length and m = floor(2^(2n)/q)
task automatic set_modulus(coef_t modulus);
    nbits_t      len;
    logic [63:0] num;
    len    = bit_length(modulus);
    num    = 64'd1 << (2 * len);
    q      = modulus;
    n_bits = len;
    m      = 25'(num / 64'(modulus));
endtask

// one enable pulse with its expected value queued for the scoreboard
task automatic send_item(coef_t x, coef_t y);
    enable = 1'b1;
    a      = x;
    b      = y;
    exp_val.push_back(mod_mult(x, y, q));
    // counter still shows the previous edge here
    exp_cyc.push_back(cyc + pipe_depth + 1);
    @(posedge poly_mm_clk);
    #drive_delay;
    enable = 1'b0;
endtask

task automatic idle_cycles(int n);
    repeat (n) begin
        @(posedge poly_mm_clk);
        #drive_delay;
    end
endtask

// bounded wait until every queued item has come out
task automatic wait_drain();
    int t;
    t = 0;
    while ((exp_val.size() != 0) && (t < 20)) begin
        @(posedge poly_mm_clk);
        #drive_delay;
        t++;
    end
    if (exp_val.size() != 0) begin
        $display("timeout at %0t ns: %0d items never came out", $time, exp_val.size());
        errors++;
    end
endtask

// outputs stay zero through reset and after it with no items
task automatic reset_state_check();
    int i;
    poly_mm_rst_n = 1'b0;
    for (i = 0; i < 5; i++) begin
        @(negedge poly_mm_clk);
        checks++;
        if (valid !== 1'b0) begin
            $display("error at %0t ns: valid expected 0 got %0b", $time, valid);
            errors++;
        end
        if (result !== 24'd0) begin
            $display("error at %0t ns: result expected 0 got %0d", $time, result);
            errors++;
        end
        // release after two rising edges
        if (i == 0) begin
            @(posedge poly_mm_clk);
            #drive_delay;
            poly_mm_rst_n = 1'b1;
        end
    end
    @(posedge poly_mm_clk);
    #drive_delay;
endtask

// corner operands run twice so the lfsr blinds them differently
task automatic directed_products();
    coef_t xs [0:11];
    coef_t ys [0:11];
    int    pass;
    int    i;
    xs = '{24'd0, 24'd0, 24'd2500, 24'd1, 24'd1, 24'd3328,
           24'd3328, 24'd3328, 24'd1664, 24'd2, 24'd1665, 24'd17};
    ys = '{24'd0, 24'd1234, 24'd0, 24'd1, 24'd3328, 24'd1,
           24'd3328, 24'd0, 24'd2, 24'd1665, 24'd1665, 24'd196};
    set_modulus(24'd3329);
    for (pass = 0; pass < 2; pass++) begin
        for (i = 0; i < 12; i++) begin
            send_item(xs[i], ys[i]);
            if (pass == 1) idle_cycles(1);
        end
    end
    wait_drain();
endtask

// enable high every cycle
task automatic random_stream();
    int i;
    set_modulus(24'd3329);
    for (i = 0; i < 200; i++) begin
        send_item(rand_below(q), rand_below(q));
    end
    wait_drain();
endtask

// dilithium modulus then a small odd one
task automatic other_moduli();
    int i;
    set_modulus(24'd8380417);
    for (i = 0; i < 60; i++) begin
        send_item(rand_below(q), rand_below(q));
    end
    wait_drain();
    set_modulus(24'd251);
    for (i = 0; i < 60; i++) begin
        send_item(rand_below(q), rand_below(q));
    end
    wait_drain();
endtask

// random idle gaps of 0 to 4 cycles between items
task automatic gapped_enables();
    int i;
    set_modulus(24'd3329);
    for (i = 0; i < 40; i++) begin
        send_item(rand_below(q), rand_below(q));
        idle_cycles(int'(rand_below(24'd5)));
    end
    wait_drain();
endtask

`endif

//--- verification/tb_poly_mm_barrett.sv
`timescale 1ns/100ps

module tb_poly_mm_barrett;

    import poly_mm_pkg::*;

    localparam int clk_period  = 4;
    // inputs change this long after the rising edge
    localparam int drive_delay = 1;

    logic   poly_mm_clk;
    logic   poly_mm_rst_n;
    logic   enable;
    coef_t  a;
    coef_t  b;
    coef_t  q;
    nbits_t n_bits;
    wide_t  m;
    logic   valid;
    coef_t  result;

    // random stream state
    int seed   = 38376;
    // rising edges seen so far
    int cyc    = 0;
    int checks = 0;
    int errors = 0;
    // expected results and the cycle each one is due, in issue order
    coef_t exp_val[$];
    int    exp_cyc[$];

    poly_mm_barrett dut (
        .poly_mm_clk   (poly_mm_clk),
        .poly_mm_rst_n (poly_mm_rst_n),
        .enable        (enable),
        .a             (a),
        .b             (b),
        .q             (q),
        .n_bits        (n_bits),
        .m             (m),
        .valid         (valid),
        .result        (result)
    );

    initial begin
        poly_mm_clk = 1'b0;
        forever #(clk_period / 2) poly_mm_clk = ~poly_mm_clk;
    end

    always @(posedge poly_mm_clk) begin
        cyc <= cyc + 1;
    end

    `include "tb_poly_mm_tasks.svh"

    // scoreboard, sampled at the falling edge where outputs are settled
    task automatic compare_output();
        coef_t want;
        int    want_cyc;
        if (valid === 1'b1) begin
            checks++;
            if (exp_val.size() == 0) begin
                $display("valid went high at %0t ns with no item outstanding", $time);
                errors++;
            end else begin
                want     = exp_val.pop_front();
                want_cyc = exp_cyc.pop_front();
                if (cyc != want_cyc) begin
                    $display("error at %0t ns: valid cycle expected %0d got %0d",
                             $time, want_cyc, cyc);
                    errors++;
                end
                if (result !== want) begin
                    $display("error at %0t ns: result expected %0d got %0d",
                             $time, want, result);
                    errors++;
                end
            end
        end else if (valid !== 1'b0) begin
            $display("valid is unknown at %0t ns", $time);
            errors++;
        end else if ((exp_cyc.size() != 0) && (exp_cyc[0] <= cyc)) begin
            // item due now but no valid
            $display("no valid at %0t ns for an item that was due", $time);
            errors++;
            want     = exp_val.pop_front();
            want_cyc = exp_cyc.pop_front();
        end
    endtask

    initial begin
        poly_mm_rst_n = 1'b0;
        enable        = 1'b0;
        a             = '0;
        b             = '0;
        set_modulus(24'd3329);
        reset_state_check();
        // monitor runs until the end of the test
        fork
            forever begin
                @(negedge poly_mm_clk);
                compare_output();
            end
        join_none
        directed_products();
        random_stream();
        other_moduli();
        gapped_enables();
        wait_drain();
        idle_cycles(2);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+verification
verilog/poly_mm_pkg.sv
verilog/blind_lfsr.sv
verilog/blind_unit.sv
verilog/barrett_quotient.sv
verilog/barrett_remainder.sv
verilog/poly_mm_barrett.sv
verification/tb_poly_mm_barrett.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the barrett multiplier testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_poly_mm_barrett \
    -Mdir obj_dir \
    -f src.f

sim_out=$(./obj_dir/Vtb_poly_mm_barrett)
echo "$sim_out"

if grep -qx "Test OK" <<< "$sim_out"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
